// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  - files:
      - rtl/fetchPkg.sv
      - rtl/romBusIf.sv
      - rtl/programRom.sv
      - rtl/pcCounter.sv
      - rtl/instrAssembler.sv
      - rtl/fetchControl.sv
      - rtl/fetchTop.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/fetchTb.sv

// ==== bench/clockGen.sv ====
`timescale 1ns/10ps

module clockGen
(
	output logic clk
);
	localparam time HALF_PERIOD = 20ns; // 40 ns period

	initial
	begin
		clk = 1'b0; // First rising edge at 20 ns
		forever
		begin
			#HALF_PERIOD clk = ~clk;
		end
	end

endmodule

// ==== bench/fetchTb.sv ====
`timescale 1ns/10ps

module fetchTb;
	import fetchPkg::*;

	// Cycle budgets per test
	localparam int INSTR_TIMEOUT  = 40;  // Worst case with credit delays
	localparam int RESET_CYCLES   = 16;
	localparam int FIRST_BUDGET   = RESET_CYCLES + 2 + INSTR_TIMEOUT;
	localparam int STREAM_BUDGET  = 24 * INSTR_TIMEOUT;
	localparam int JUMP_BUDGET    = 8 * INSTR_TIMEOUT;
	localparam int BACK_BUDGET    = RESET_CYCLES + 2 + 200 + 6 * INSTR_TIMEOUT;
	localparam int INTA_BUDGET    = 2 * INSTR_TIMEOUT + 60 + 2 * INSTR_TIMEOUT;
	localparam int RESET2_BUDGET  = 3 * INSTR_TIMEOUT + RESET_CYCLES + 2 + 200;
	localparam int TOTAL_BUDGET   = FIRST_BUDGET + STREAM_BUDGET + JUMP_BUDGET
		+ BACK_BUDGET + INTA_BUDGET + RESET2_BUDGET;

	logic     rd;
	logic     eprom_reset;
	logic     inta;
	logic     creditReturn;
	instr_t   instr;
	busAddr_t instrAddr;
	logic     instrValid;

	word_t    modelMem [0:63];  // Own copy of the program image
	busAddr_t modelAddr;        // Address the model expects next
	instr_t   gotInstr [$];     // Observed instructions
	busAddr_t gotAddr [$];
	instr_t   lastInstr;        // Last instruction taken from the DUT
	busAddr_t lastAddr;         // Its address
	int       pulseCount;       // All instrValid pulses seen
	int       outstanding;      // Credits held by decode
	int       delayCnt;         // Cycles until next return
	logic     returnEnable;     // Decode side consuming
	logic     resetValidSeen;   // instrValid high inside reset
	int       resetNegedges;
	int       errorCount;
	integer   seed;

	clockGen uClk
	(
		.clk (rd)
	);

	fetchTop uut
	(
		.rd           (rd),
		.eprom_reset  (eprom_reset),
		.inta         (inta),
		.creditReturn (creditReturn),
		.instr        (instr),
		.instrAddr    (instrAddr),
		.instrValid   (instrValid)
	);

	task automatic reportFailure(input string line);
		begin
			errorCount++;
			$display("%s", line);
			$display("CHECKS FAILED");
			$fatal(1, "Stopping at first error");
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		begin
			assert (actual === expected)
			else reportFailure($sformatf("Fail %s: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	// Reference model: fetch the word pair at the address
	function automatic instr_t modelInstr(input busAddr_t addr);
		int idx;
		begin
			idx = int'(addr - ROM_BASE);
			return {modelMem[idx + 1], modelMem[idx]}; // Opcode high
		end
	endfunction

	// Jump rule, otherwise two words on
	function automatic busAddr_t modelNext(input busAddr_t addr);
		instr_t w;
		begin
			w = modelInstr(addr);
			if (w[31:16] == 16'h0000 && w[15])
			begin
				return w[15:0];
			end
			return addr + 16'd2;
		end
	endfunction

	// Sample where outputs are settled
	always @(negedge rd)
	begin
		if (eprom_reset)
		begin
			resetNegedges++;
			if (resetNegedges > 1 && instrValid !== 1'b0)
			begin
				resetValidSeen = 1'b1; // DUT reset is in force here
			end
		end
		else if (instrValid === 1'b1)
		begin
			gotInstr.push_back(instr);
			gotAddr.push_back(instrAddr);
			pulseCount++;
			outstanding++; // One slot now held by decode
		end
	end

	// Decode side returns credits after random delays
	always @(posedge rd)
	begin
		if (eprom_reset || !returnEnable)
		begin
			creditReturn <= 1'b0;
		end
		else if (outstanding > 0 && delayCnt == 0)
		begin
			creditReturn <= 1'b1;
			outstanding--;
			delayCnt = $random(seed) & 7; // 0 to 7 idle cycles
		end
		else
		begin
			creditReturn <= 1'b0;
			if (delayCnt > 0)
			begin
				delayCnt--;
			end
		end
	end

	// Watchdog over the whole run
	initial
	begin
		repeat (TOTAL_BUDGET) @(posedge rd);
		reportFailure("Timeout: the tests did not finish within their cycle budget");
	end

	task automatic applyReset();
		begin
			returnEnable = 1'b0;
			@(posedge rd);
			eprom_reset    <= 1'b1;
			resetNegedges  = 0;
			resetValidSeen = 1'b0;
			repeat (RESET_CYCLES) @(posedge rd);
			eprom_reset <= 1'b0;
			gotInstr.delete();
			gotAddr.delete();
			outstanding = 0;  // Decode queue empties with reset
			delayCnt    = 0;
			modelAddr   = ROM_BASE;
		end
	endtask

	task automatic checkQuietReset(input string name);
		begin
			assert (!resetValidSeen)
			else reportFailure($sformatf("%s: instrValid went high during reset", name));
		end
	endtask

	// Wait for the next instruction and compare it with the model
	task automatic checkNext(input string name);
		int waited;
		instr_t   gi;
		busAddr_t ga;
		begin
			waited = 0;
			while (gotInstr.size() == 0)
			begin
				@(negedge rd);
				waited++;
				assert (waited < INSTR_TIMEOUT + 70)
				else reportFailure($sformatf("%s: no instruction arrived in time", name));
			end
			gi = gotInstr.pop_front();
			ga = gotAddr.pop_front();
			lastInstr = gi;
			lastAddr  = ga;
			checkValue({name, " addr"}, 32'(modelAddr), 32'(ga));
			checkValue({name, " instr"}, modelInstr(modelAddr), gi);
			modelAddr = modelNext(modelAddr);
		end
	endtask

	task automatic firstInstrTest();
		begin
			applyReset();
			checkQuietReset("firstInstr");
			returnEnable = 1'b1;
			checkNext("firstInstr");
			checkValue("firstInstr fixed addr", 32'h0000_8000, 32'(lastAddr));
			checkValue("firstInstr fixed word", 32'h4803_0002, lastInstr);
		end
	endtask

	task automatic streamTest();
		begin
			for (int i = 1; i < 25; i++)
			begin
				checkNext($sformatf("stream[%0d]", i));
			end
			checkValue("stream end addr", 32'h0000_8028, 32'(lastAddr));
		end
	endtask

	task automatic jumpHoldTest();
		begin
			for (int i = 0; i < 8; i++)
			begin
				checkNext($sformatf("jumpHold[%0d]", i));
				checkValue("jumpHold addr", 32'h0000_8028, 32'(lastAddr));
				checkValue("jumpHold word", 32'h0000_8028, lastInstr);
			end
		end
	endtask

	task automatic backPressureTest();
		int start;
		begin
			applyReset(); // Fresh stream with distinct addresses
			start = pulseCount;
			repeat (200) @(posedge rd);
			assert (pulseCount - start <= int'(CREDIT_MAX))
			else reportFailure($sformatf("Fail backPressure: expected at most %0d, actual %0d",
				CREDIT_MAX, pulseCount - start));
			returnEnable = 1'b1;
			for (int i = 0; i < 10; i++)
			begin
				checkNext($sformatf("backPressure[%0d]", i));
			end
		end
	endtask

	task automatic intaStallTest();
		int waited;
		int start;
		begin
			waited = 0;
			@(negedge rd);
			while (instrValid !== 1'b1)
			begin
				@(negedge rd);
				waited++;
				assert (waited < INSTR_TIMEOUT)
				else reportFailure("intaStall: no instruction before raising inta");
			end
			@(posedge rd);
			inta <= 1'b1;  // Lands while fetch sits in IDLE
			start = pulseCount;
			repeat (60) @(posedge rd);
			assert (pulseCount == start)
			else reportFailure($sformatf("Fail intaStall: expected %0d, actual %0d",
				start, pulseCount));
			inta <= 1'b0;
			while (gotInstr.size() > 0)
			begin
				checkNext("intaStall before");
			end
			checkNext("intaStall after");
		end
	endtask

	task automatic midResetTest();
		int start;
		begin
			for (int i = 0; i < 3; i++)
			begin
				checkNext("midReset run");
			end
			applyReset();
			checkQuietReset("midReset");
			start = pulseCount;
			repeat (200) @(posedge rd);
			checkValue("midReset credits", 32'(CREDIT_MAX), 32'(pulseCount - start));
			checkValue("midReset restart", 32'h0000_8000, 32'(gotAddr[0]));
			for (int i = 0; i < int'(CREDIT_MAX); i++)
			begin
				checkNext($sformatf("midReset[%0d]", i));
			end
		end
	endtask

	initial
	begin
		eprom_reset    = 1'b1;
		inta           = 1'b0;
		creditReturn   = 1'b0;
		returnEnable   = 1'b0;
		resetValidSeen = 1'b0;
		resetNegedges  = 0;
		pulseCount     = 0;
		outstanding    = 0;
		delayCnt       = 0;
		errorCount     = 0;
		seed           = 50;
		lastInstr      = '0;
		lastAddr       = '0;
		modelAddr      = ROM_BASE;
		$readmemh("rtl/program.hex", modelMem);

		firstInstrTest();
		streamTest();
		jumpHoldTest();
		backPressureTest();
		intaStallTest();
		midResetTest();

		if (errorCount == 0)
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
rtl/fetchPkg.sv
rtl/romBusIf.sv
rtl/programRom.sv
rtl/pcCounter.sv
rtl/instrAssembler.sv
rtl/fetchControl.sv
rtl/fetchTop.sv
bench/clockGen.sv
bench/fetchTb.sv

// ==== rtl/fetchControl.sv ====
`timescale 1ns/10ps

module fetchControl
(
	input  logic  rd,
	input  logic  eprom_reset,
	input  logic  creditReturn,
	romBusIf.ctrl bus,
	output logic  advance,
	output logic  load,
	output logic  captureLo,
	output logic  captureHi,
	input  logic  isJump,
	output logic  instrValid
);
	import fetchPkg::*;

	fetchState_t state;     // Current state
	fetchState_t nextState; // State after this edge
	credit_t     credits;   // Free slots in decode
	logic        haveCredit;

	assign haveCredit = (credits != '0);

	// State register and credit counter
	always_ff @(posedge rd)
	begin
		if (eprom_reset)
		begin
			state   <= IDLE;
			credits <= CREDIT_MAX; // Decode queue empty
		end
		else
		begin
			state <= nextState;
			case ({instrValid, creditReturn})
				2'b10: credits <= credits - credit_t'(1); // Slot used
				2'b01: credits <= credits + credit_t'(1); // Slot freed
				default: credits <= credits;              // None or both
			endcase
		end
	end

	// Next state and strobes
	always_comb
	begin
		nextState  = state;
		advance    = 1'b0;
		load       = 1'b0;
		captureLo  = 1'b0;
		captureHi  = 1'b0;
		instrValid = 1'b0;
		case (state)
			IDLE:
			begin
				if (haveCredit)
				begin
					nextState = REQ_LO; // Start a new instruction
				end
			end
			REQ_LO: nextState = WAIT_LO;
			WAIT_LO:
			begin
				if (bus.dataValid)
				begin
					captureLo = 1'b1;
					advance   = 1'b1;
					nextState = REQ_HI;
				end
				else
				begin
					nextState = REQ_LO; // No data, ask again
				end
			end
			REQ_HI: nextState = WAIT_HI;
			WAIT_HI:
			begin
				if (bus.dataValid)
				begin
					captureHi = 1'b1;
					advance   = 1'b1;
					nextState = ISSUE;
				end
				else
				begin
					nextState = REQ_HI; // Retry opcode word
				end
			end
			ISSUE:
			begin
				instrValid = 1'b1;
				load       = isJump; // Redirect PC on jump
				nextState  = IDLE;
			end
			default: nextState = IDLE;
		endcase
	end

	// Word request in either request state
	assign bus.fetchReq = (state == REQ_LO) || (state == REQ_HI);

endmodule

// ==== rtl/fetchPkg.sv ====
package fetchPkg;

	// Widths with a meaning of their own
	typedef logic [15:0] word_t;      // One memory or instruction word
	typedef logic [15:0] busAddr_t;   // Processor bus address
	typedef logic [14:0] romIndex_t;  // Word index inside program memory
	typedef logic [31:0] instr_t;     // Opcode word high, immediate word low
	typedef logic [2:0]  credit_t;    // Holds 0 to CREDIT_MAX

	// Decode queue depth seen by fetch
	localparam credit_t CREDIT_MAX = 3'd4;

	// Program memory geometry
	localparam int       ROM_DEPTH = 32768;   // 32K words
	localparam busAddr_t ROM_BASE  = 16'h8000; // First word, PC reset value

	// Program image loaded at time zero
	localparam string ROM_IMAGE = "rtl/program.hex";

	// Second word of a jump is all zero
	localparam word_t JUMP_OPCODE = 16'h0000;

	// Fetch controller states
	typedef enum logic [2:0]
	{
		IDLE,     // Waiting for a credit
		REQ_LO,   // Request immediate word
		WAIT_LO,  // Immediate word returns
		REQ_HI,   // Request opcode word
		WAIT_HI,  // Opcode word returns
		ISSUE     // Hand instruction to decode
	} fetchState_t;

endpackage

// ==== rtl/fetchTop.sv ====
`timescale 1ns/10ps

module fetchTop
(
	input  logic               rd,
	input  logic               eprom_reset,
	input  logic               inta,
	input  logic               creditReturn,
	output fetchPkg::instr_t   instr,
	output fetchPkg::busAddr_t instrAddr,
	output logic               instrValid
);
	import fetchPkg::*;

	logic     advance;    // PC to next word
	logic     load;       // PC takes jump target
	logic     captureLo;  // Latch immediate word
	logic     captureHi;  // Latch opcode word
	logic     isJump;     // Assembled instruction is a jump
	busAddr_t jumpTarget; // Where the jump goes

	romBusIf bus();

	programRom uRom
	(
		.rd   (rd),
		.inta (inta),
		.bus  (bus)
	);

	pcCounter uPc
	(
		.rd          (rd),
		.eprom_reset (eprom_reset),
		.advance     (advance),
		.load        (load),
		.target      (jumpTarget),
		.bus         (bus)
	);

	instrAssembler uAsm
	(
		.rd          (rd),
		.eprom_reset (eprom_reset),
		.bus         (bus),
		.captureLo   (captureLo),
		.captureHi   (captureHi),
		.instr       (instr),
		.instrAddr   (instrAddr),
		.isJump      (isJump),
		.jumpTarget  (jumpTarget)
	);

	fetchControl uCtrl
	(
		.rd           (rd),
		.eprom_reset  (eprom_reset),
		.creditReturn (creditReturn),
		.bus          (bus),
		.advance      (advance),
		.load         (load),
		.captureLo    (captureLo),
		.captureHi    (captureHi),
		.isJump       (isJump),
		.instrValid   (instrValid)
	);

endmodule

// ==== rtl/instrAssembler.sv ====
`timescale 1ns/10ps

module instrAssembler
(
	input  logic                rd,
	input  logic                eprom_reset,
	romBusIf.ctrl               bus,
	input  logic                captureLo,
	input  logic                captureHi,
	output fetchPkg::instr_t    instr,
	output fetchPkg::busAddr_t  instrAddr,
	output logic                isJump,
	output fetchPkg::busAddr_t  jumpTarget
);
	import fetchPkg::*;

	word_t    immWord;  // First word of the pair
	word_t    opWord;   // Second word of the pair
	busAddr_t loAddr;   // Where the immediate word came from
	busAddr_t issueAddr; // Address of the complete instruction

	// Immediate word and its address
	always_ff @(posedge rd)
	begin
		if (eprom_reset)
		begin
			immWord <= '0;
			loAddr  <= ROM_BASE;
		end
		else if (captureLo)
		begin
			immWord <= bus.data;
			loAddr  <= bus.addr; // PC still points at this word
		end
	end

	// Opcode word completes the instruction
	always_ff @(posedge rd)
	begin
		if (eprom_reset)
		begin
			opWord    <= '0;
			issueAddr <= ROM_BASE;
		end
		else if (captureHi)
		begin
			opWord    <= bus.data;
			issueAddr <= loAddr;
		end
	end

	assign instr     = {opWord, immWord}; // Opcode high, immediate low
	assign instrAddr = issueAddr;

	// Unconditional jump: zero opcode, target in upper half
	assign isJump     = (opWord == JUMP_OPCODE) && immWord[15];
	assign jumpTarget = immWord;

endmodule

// ==== rtl/pcCounter.sv ====
`timescale 1ns/10ps

module pcCounter
(
	input logic             rd,
	input logic             eprom_reset,
	input logic             advance,
	input logic             load,
	input fetchPkg::busAddr_t target,
	romBusIf.pc             bus
);
	import fetchPkg::*;

	busAddr_t pc; // Current bus address

	always_ff @(posedge rd)
	begin
		if (eprom_reset)
		begin
			pc <= ROM_BASE; // Start of program memory
		end
		else if (load)
		begin
			pc <= target; // Jump wins over advance
		end
		else if (advance)
		begin
			pc <= pc + busAddr_t'(1); // Next word
		end
	end

	// Address and strobe leave together
	assign bus.addr = pc;
	assign bus.req  = bus.fetchReq;

endmodule

// ==== rtl/program.hex ====
// One 16-bit word per line, bus addresses 0x8000 to 0x8029
// Even address holds the immediate word, odd address the opcode word
0002
4803
0011
1204
00a5
2310
7fff
3a01
0100
4c22
1234
5105
0042
6a33
0003
7104
00ff
2b01
0800
3302
0555
4e10
0009
1801
7abc
2207
0010
6c05
0000
1111
00c8
5a02
0077
4403
3030
2c11
0001
7f00
0404
1a06
8028
0000

// ==== rtl/programRom.sv ====
`timescale 1ns/10ps

module programRom
(
	input logic rd,
	input logic inta,
	romBusIf.rom bus
);
	import fetchPkg::*;

	word_t     mem [ROM_DEPTH]; // 32K x 16 program store
	romIndex_t romIndex;        // Word inside the memory
	logic      cs;              // Chip select

	// Program image comes from a data file
	initial
	begin
		$readmemh(ROM_IMAGE, mem);
	end

	assign romIndex = bus.addr[14:0]; // Drop the select bit

	// Upper half of the address space, and not during interrupt acknowledge
	assign cs = bus.req && bus.addr[15] && !inta;

	// Registered read, valid one cycle after the request
	always_ff @(posedge rd)
	begin
		bus.dataValid <= cs; // Low when not selected, so fetch retries
		if (cs)
		begin
			bus.data <= mem[romIndex];
		end
	end

endmodule

// ==== rtl/romBusIf.sv ====
`timescale 1ns/10ps

interface romBusIf;
	import fetchPkg::*;

	busAddr_t addr;      // Word address from the PC
	logic     req;       // Read strobe seen by memory
	logic     fetchReq;  // Controller asks for a word
	word_t    data;      // Registered read data
	logic     dataValid; // Data returned this cycle

	// Bus master side, owned by the program counter
	modport pc
	(
		output addr,
		output req,
		input  fetchReq
	);

	// Program memory side
	modport rom
	(
		input  addr,
		input  req,
		output data,
		output dataValid
	);

	// Fetch control and instruction capture
	modport ctrl
	(
		input  req,
		input  dataValid,
		input  data,
		input  addr,
		output fetchReq
	);

endinterface
